// File: Bender.yml
package:
  name: ex_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/rv_isa_pkg.sv
      - verilog/ex_pkg.sv
      - verilog/ex_decode.sv
      - verilog/ex_alu.sv
      - verilog/ex_branch.sv
      - verilog/ex_mem_access.sv
      - verilog/ex_result.sv
      - verilog/ex_top.sv
      - target: simulation
        files:
          - verification/ex_chk.sv
          - verification/tb_ex_top.sv

// File: include/ex_defines.svh
/*
 * execute stage widths and fixed encodings
 */
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// data and address width
`define EX_XLEN        32
// register file address width
`define EX_REG_ADDR_W  5

`define EX_NOP_INST    32'h0000_0013  // addi x0, x0, 0

`endif

// File: project.f
+incdir+include
verilog/rv_isa_pkg.sv
verilog/ex_pkg.sv
verilog/ex_decode.sv
verilog/ex_alu.sv
verilog/ex_branch.sv
verilog/ex_mem_access.sv
verilog/ex_result.sv
verilog/ex_top.sv
verification/ex_chk.sv
verification/tb_ex_top.sv

// File: verification/ex_chk.sv
/*
 * port-level assertions for the execute stage, bound to ex_top
 */
`timescale 1ns/1ps
`default_nettype none

module ex_chk (
    input wire clk_i,
    input wire rst_i,
    input wire int_assert_i,
    input wire mem_req_i,
    input wire mem_we_i,
    input wire wb_we_i,
    input wire jump_flag_i
);

    // no bus traffic while the interrupt is taken
    irq_blocks_mem: assert property (
        @(posedge clk_i) int_assert_i |-> !mem_we_i && !mem_req_i
    ) else $error("memory access while int_assert_i is high");

    reset_clears: assert property (
        @(posedge clk_i) rst_i |=> !wb_we_i && !jump_flag_i
    ) else $error("reg_we_o or jump_flag_o set after reset");

    write_has_req: assert property (
        @(posedge clk_i) mem_we_i |-> mem_req_i
    ) else $error("mem_we_o without mem_req_o");

endmodule

`default_nettype wire

// File: verification/tb_ex_top.sv
/*
 * directed testbench for the integer execute stage
 */
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module tb_ex_top;
    import rv_isa_pkg::*;
    import ex_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int ALU_REPS    = 4;
    // reset plus two cycles per directed item
    localparam int TEST_CYCLES = 5 + 2 * (ALU_REPS * 19 + 20 + 2 * 13 + 2 * 7 + 1);

    logic        clk;
    logic        rst;
    inst_t       inst;
    word_t       inst_addr;
    logic        reg_we;
    reg_addr_t   reg_waddr;
    word_t       op1;
    word_t       op2;
    word_t       op1_jump;
    word_t       op2_jump;
    word_t       reg1_rdata;
    word_t       reg2_rdata;
    word_t       mem_rdata;
    logic        int_assert;
    word_t       int_addr;
    logic        mem_req;
    logic        mem_we;
    word_t       mem_raddr;
    word_t       mem_waddr;
    word_t       mem_wdata;
    logic        wb_we;
    reg_addr_t   wb_waddr;
    word_t       wb_wdata;
    logic        jump_flag;
    word_t       jump_addr;

    logic [31:0] lfsr;
    logic        cur_we;
    reg_addr_t   cur_waddr;     // destination of the item in flight
    word_t       cur_irq_addr;

    ex_top dut0 (
        .clk_i        (clk),
        .rst_i        (rst),
        .inst_i       (inst),
        .inst_addr_i  (inst_addr),
        .reg_we_i     (reg_we),
        .reg_waddr_i  (reg_waddr),
        .op1_i        (op1),
        .op2_i        (op2),
        .op1_jump_i   (op1_jump),
        .op2_jump_i   (op2_jump),
        .reg1_rdata_i (reg1_rdata),
        .reg2_rdata_i (reg2_rdata),
        .mem_rdata_i  (mem_rdata),
        .int_assert_i (int_assert),
        .int_addr_i   (int_addr),
        .mem_req_o    (mem_req),
        .mem_we_o     (mem_we),
        .mem_raddr_o  (mem_raddr),
        .mem_waddr_o  (mem_waddr),
        .mem_wdata_o  (mem_wdata),
        .reg_we_o     (wb_we),
        .reg_waddr_o  (wb_waddr),
        .reg_wdata_o  (wb_wdata),
        .jump_flag_o  (jump_flag),
        .jump_addr_o  (jump_addr)
    );

    bind ex_top ex_chk chk0 (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .int_assert_i (int_assert_i),
        .mem_req_i    (mem_req_o),
        .mem_we_i     (mem_we_o),
        .wb_we_i      (reg_we_o),
        .jump_flag_i  (jump_flag_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_bits(int n);
        word_t v;
        int    k;
        v = '0;
        for (k = 0; k < n; k++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic word_t alu_model(funct3_t f3, logic alt, word_t a, word_t b);
        logic signed [31:0] sa;
        sa = $signed(a);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return sa >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(funct3_t f3, word_t a, word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic word_t load_model(funct3_t f3, int off, word_t w);
        word_t s;
        s = w >> (8 * off);
        case (f3)
            3'b000:  return {{24{s[7]}}, s[7:0]};
            3'b001:  return {{16{s[15]}}, s[15:0]};
            3'b100:  return {24'h0, s[7:0]};
            3'b101:  return {16'h0, s[15:0]};
            default: return s;
        endcase
    endfunction

    function automatic word_t store_model(funct3_t f3, int off, word_t old, word_t data);
        word_t mask;
        case (f3[1:0])
            2'b00:   mask = 32'h0000_00ff;
            2'b01:   mask = 32'h0000_ffff;
            default: mask = 32'hffff_ffff;
        endcase
        mask = mask << (8 * off);
        return (old & ~mask) | ((data << (8 * off)) & mask);
    endfunction

    // halves need even offsets, words offset zero
    function automatic logic misaligned(funct3_t f3, int off);
        return (f3[1:0] == 2'b01 && off[0]) || (f3[1:0] == 2'b10 && off != 0);
    endfunction

    task automatic report_mismatch(string what, word_t got, word_t exp);
        $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
        $display("Simulation failed");
        $fatal(1, "result mismatch");
    endtask

    task automatic check_word(string what, word_t got, word_t exp);
        if (got !== exp) begin
            report_mismatch(what, got, exp);
        end
    endtask

    task automatic check_addr(string what, reg_addr_t got, reg_addr_t exp);
        if (got !== exp) begin
            report_mismatch(what, word_t'(got), word_t'(exp));
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        if (got !== exp) begin
            report_mismatch(what, word_t'(got), word_t'(exp));
        end
    endtask

    task automatic check_wb(string what, word_t data);
        check_flag({what, " reg_we_o"}, wb_we, cur_we);
        check_addr({what, " reg_waddr_o"}, wb_waddr, cur_waddr);
        check_word({what, " reg_wdata_o"}, wb_wdata, data);
    endtask

    task automatic check_jump(string what, logic flag, word_t addr);
        check_flag({what, " jump_flag_o"}, jump_flag, flag);
        check_word({what, " jump_addr_o"}, jump_addr, addr);
    endtask

    // drive one item on the rising edge, return at the falling edge
    task automatic present(inst_t i, word_t a, word_t b, word_t ja, word_t jb,
                           word_t st, word_t rdata, logic irq);
        @(posedge clk);
        cur_we       = next_bit();
        cur_waddr    = reg_addr_t'(rand_bits(5));
        cur_irq_addr = rand_bits(32);
        inst       <= i;
        reg_we     <= cur_we;
        reg_waddr  <= cur_waddr;
        op1        <= a;
        op2        <= b;
        op1_jump   <= ja;
        op2_jump   <= jb;
        reg1_rdata <= a;
        reg2_rdata <= st;
        mem_rdata  <= rdata;
        int_assert <= irq;
        int_addr   <= cur_irq_addr;
        @(negedge clk);
    endtask

    // past the result register edge
    task automatic settle();
        @(negedge clk);
    endtask

    // pending write first, then a pending interrupt, both held in reset
    task automatic test_reset();
        repeat (2) @(posedge clk);
        int_assert <= 1'b1;
        @(negedge clk);
        check_flag("reset reg_we_o", wb_we, 1'b0);
        check_word("reset reg_wdata_o", wb_wdata, '0);
        repeat (2) @(posedge clk);
        rst        <= 1'b0;
        reg_we     <= 1'b0;
        op1        <= '0;
        int_assert <= 1'b0;
        @(negedge clk);
        check_flag("reset jump_flag_o", jump_flag, 1'b0);
        check_word("reset jump_addr_o", jump_addr, '0);
    endtask

    task automatic test_alu();
        int          rep;
        int          code;
        funct3_t     f3;
        logic        alt;
        logic [6:0]  f7;
        logic [11:0] imm;
        word_t       a;
        word_t       b;
        for (rep = 0; rep < ALU_REPS; rep++) begin
            for (code = 0; code < 16; code++) begin
                f3  = funct3_t'(code[2:0]);
                alt = code[3];
                if (alt && f3 != 3'b000 && f3 != 3'b101) begin
                    continue;
                end
                f7 = alt ? F7_ALT : F7_BASE;
                a  = rand_bits(32);
                b  = rand_bits(32);
                present({f7, 5'd2, 5'd1, f3, 5'd3, OP_REG}, a, b, '0, '0, '0, '0, 1'b0);
                settle();
                check_wb("alu reg", alu_model(f3, alt, a, b));
                if (alt && f3 == 3'b000) begin
                    continue;  // there is no subi
                end
                imm = 12'(rand_bits(12));
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm[11:5] = f7;
                end
                b = {{20{imm[11]}}, imm};
                present({imm, 5'd1, f3, 5'd3, OP_IMM}, a, b, '0, '0, '0, '0, 1'b0);
                settle();
                check_wb("alu imm", alu_model(f3, alt, a, b));
            end
        end
    endtask

    task automatic test_branch();
        int      k;
        int      pair;
        funct3_t f3;
        logic    taken;
        word_t   x;
        word_t   y;
        word_t   a;
        word_t   b;
        word_t   ja;
        word_t   jb;
        x = rand_bits(32);
        y = x ^ 32'h8000_0001;  // differs in sign and value
        for (k = 0; k < 8; k++) begin
            f3 = funct3_t'(k);
            if (f3 == 3'b010 || f3 == 3'b011) begin
                continue;
            end
            for (pair = 0; pair < 3; pair++) begin
                a     = (pair == 2) ? y : x;
                b     = (pair == 1) ? y : x;
                ja    = rand_bits(32);
                jb    = rand_bits(12);
                taken = branch_model(f3, a, b);
                present({7'h0, 5'd2, 5'd1, f3, 5'd0, OP_BRANCH}, a, b, ja, jb, '0, '0, 1'b0);
                settle();
                check_jump("branch", taken, taken ? ja + jb : '0);
                check_wb("branch", '0);
            end
        end
        for (k = 0; k < 2; k++) begin
            a  = rand_bits(32) & ~32'h3;
            ja = rand_bits(32);
            jb = rand_bits(20);
            present((k == 0) ? {20'h0, 5'd1, OP_JAL} : {12'h0, 5'd1, 3'b000, 5'd1, OP_JALR},
                    a, 32'd4, ja, jb, '0, '0, 1'b0);
            settle();
            check_jump("jal/jalr", 1'b1, ja + jb);
            check_wb("jal/jalr link", a + 32'd4);
        end
    endtask

    task automatic test_load();
        int      rep;
        int      k;
        int      off;
        funct3_t f3;
        word_t   base;
        word_t   rdata;
        for (rep = 0; rep < 2; rep++) begin
            for (k = 0; k < 8; k++) begin
                f3 = funct3_t'(k);
                if (f3 == 3'b011 || f3 == 3'b110 || f3 == 3'b111) begin
                    continue;
                end
                for (off = 0; off < 4; off++) begin
                    if (misaligned(f3, off)) begin
                        continue;
                    end
                    base  = rand_bits(32) & ~32'h3;
                    rdata = rand_bits(32);
                    present({12'(off), 5'd1, f3, 5'd3, OP_LOAD}, base, word_t'(off),
                            '0, '0, '0, rdata, 1'b0);
                    check_flag("load mem_req_o", mem_req, 1'b1);
                    check_flag("load mem_we_o", mem_we, 1'b0);
                    check_word("load mem_raddr_o", mem_raddr, base + word_t'(off));
                    settle();
                    check_wb("load", load_model(f3, off, rdata));
                end
            end
        end
    endtask

    task automatic test_store();
        int      rep;
        int      k;
        int      off;
        funct3_t f3;
        word_t   addr;
        word_t   old;
        word_t   data;
        for (rep = 0; rep < 2; rep++) begin
            for (k = 0; k < 3; k++) begin
                f3 = funct3_t'(k);
                for (off = 0; off < 4; off++) begin
                    if (misaligned(f3, off)) begin
                        continue;
                    end
                    addr = (rand_bits(32) & ~32'h3) + word_t'(off);
                    old  = rand_bits(32);
                    data = rand_bits(32);
                    present({7'h0, 5'd2, 5'd1, f3, 5'(off), OP_STORE}, addr, '0,
                            '0, '0, data, old, 1'b0);
                    check_flag("store mem_we_o", mem_we, 1'b1);
                    check_flag("store mem_req_o", mem_req, 1'b1);
                    check_word("store mem_raddr_o", mem_raddr, addr);
                    check_word("store mem_waddr_o", mem_waddr, addr);
                    check_word("store mem_wdata_o", mem_wdata, store_model(f3, off, old, data));
                    settle();
                    check_wb("store", '0);
                end
            end
        end
    endtask

    task automatic test_interrupt();
        word_t addr;
        addr = rand_bits(32) & ~32'h3;
        present({7'h0, 5'd2, 5'd1, 3'b010, 5'd0, OP_STORE}, addr, '0, '0, '0,
                rand_bits(32), rand_bits(32), 1'b1);
        check_flag("irq mem_we_o", mem_we, 1'b0);
        check_flag("irq mem_req_o", mem_req, 1'b0);
        settle();
        check_flag("irq reg_we_o", wb_we, 1'b0);
        check_jump("irq", 1'b1, cur_irq_addr);
    endtask

    initial begin
        lfsr         = 32'h88df004a;
        clk          = 1'b0;
        rst          = 1'b1;
        inst         = `EX_NOP_INST;
        inst_addr    = 32'h0000_1000;
        reg_we       = 1'b1;
        reg_waddr    = '0;
        op1          = 32'h0000_5a5a;
        op2          = '0;
        op1_jump     = '0;
        op2_jump     = '0;
        reg1_rdata   = '0;
        reg2_rdata   = '0;
        mem_rdata    = '0;
        int_assert   = 1'b0;
        int_addr     = 32'h0000_0200;
        cur_we       = 1'b0;
        cur_waddr    = '0;
        cur_irq_addr = '0;
        test_reset();
        test_alu();
        test_branch();
        test_load();
        test_store();
        test_interrupt();
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin
        #((TEST_CYCLES + 20) * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", TEST_CYCLES + 20);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: verilog/ex_alu.sv
/*
 * integer ALU with the compare flags shared by branch resolution
 */
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  wire ex_pkg::alu_op_e alu_op_i,
    input  wire ex_pkg::word_t   op1_i,
    input  wire ex_pkg::word_t   op2_i,
    output ex_pkg::word_t        alu_result_o,
    output logic                 lt_s_o,
    output logic                 lt_u_o,
    output logic                 eq_o
);
    import ex_pkg::*;

    logic [4:0] shamt;

    assign shamt = op2_i[4:0];  // imm and reg forms alike

    assign lt_s_o = $signed(op1_i) < $signed(op2_i);
    assign lt_u_o = op1_i < op2_i;
    assign eq_o   = (op1_i == op2_i);

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  alu_result_o = op1_i + op2_i;
            ALU_SUB:  alu_result_o = op1_i - op2_i;
            ALU_SLT:  alu_result_o = word_t'(lt_s_o);
            ALU_SLTU: alu_result_o = word_t'(lt_u_o);
            ALU_XOR:  alu_result_o = op1_i ^ op2_i;
            ALU_OR:   alu_result_o = op1_i | op2_i;
            ALU_AND:  alu_result_o = op1_i & op2_i;
            ALU_SLL:  alu_result_o = op1_i << shamt;
            ALU_SRL:  alu_result_o = op1_i >> shamt;
            ALU_SRA:  alu_result_o = word_t'($signed(op1_i) >>> shamt);  // sign fill
            default:  alu_result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/ex_branch.sv
/*
 * branch condition from the ALU flags, and the jump target
 */
`timescale 1ns/1ps
`default_nettype none

module ex_branch (
    input  wire ex_pkg::br_cond_e br_cond_i,
    input  wire                   lt_s_i,
    input  wire                   lt_u_i,
    input  wire                   eq_i,
    input  wire ex_pkg::word_t    op1_jump_i,
    input  wire ex_pkg::word_t    op2_jump_i,
    output logic                  take_jump_o,
    output ex_pkg::word_t         jump_target_o
);
    import ex_pkg::*;

    always_comb begin
        case (br_cond_i)
            BR_EQ:     take_jump_o = eq_i;
            BR_NE:     take_jump_o = !eq_i;
            BR_LT:     take_jump_o = lt_s_i;
            BR_GE:     take_jump_o = !lt_s_i;
            BR_LTU:    take_jump_o = lt_u_i;
            BR_GEU:    take_jump_o = !lt_u_i;
            BR_ALWAYS: take_jump_o = 1'b1;  // jal, jalr, fence
            default:   take_jump_o = 1'b0;
        endcase
    end

    // target stays zero on not taken
    assign jump_target_o = take_jump_o ? (op1_jump_i + op2_jump_i) : '0;

endmodule

`default_nettype wire

// File: verilog/ex_decode.sv
/*
 * execute decode: maps the instruction word onto ALU, branch,
 * memory and write-back operation classes
 */
`timescale 1ns/1ps
`default_nettype none

module ex_decode (
    input  wire rv_isa_pkg::inst_t inst_i,
    output ex_pkg::alu_op_e        alu_op_o,
    output ex_pkg::br_cond_e       br_cond_o,
    output ex_pkg::mem_op_e        mem_op_o,
    output ex_pkg::wb_sel_e        wb_sel_o
);
    import rv_isa_pkg::*;
    import ex_pkg::*;

    opcode_e    opcode;
    funct3_t    funct3;
    logic [6:0] funct7;
    logic       f7_ok;      // base or alternate form
    logic       shift_op;
    alu_op_e    arith_op;

    assign opcode   = opcode_e'(inst_i[6:0]);
    assign funct3   = inst_i[14:12];
    assign funct7   = inst_i[31:25];
    assign f7_ok    = (funct7 == F7_BASE) || (funct7 == F7_ALT);
    assign shift_op = (funct3 == F3_SLL) || (funct3 == F3_SR);

    always_comb begin
        case (funct3)
            F3_ADD_SUB: arith_op = (opcode == OP_REG && inst_i[30]) ? ALU_SUB : ALU_ADD;
            F3_SLL:     arith_op = ALU_SLL;
            F3_SLT:     arith_op = ALU_SLT;
            F3_SLTU:    arith_op = ALU_SLTU;
            F3_XOR:     arith_op = ALU_XOR;
            F3_SR:      arith_op = inst_i[30] ? ALU_SRA : ALU_SRL;
            F3_OR:      arith_op = ALU_OR;
            F3_AND:     arith_op = ALU_AND;
            default:    arith_op = ALU_ADD;
        endcase
    end

    always_comb begin
        alu_op_o  = ALU_ADD;  // address and link values use add
        br_cond_o = BR_NONE;
        mem_op_o  = MEM_NONE;
        wb_sel_o  = WB_NONE;
        case (opcode)
            OP_IMM: begin
                if (!shift_op || f7_ok) begin  // imm bits only matter for shifts
                    alu_op_o = arith_op;
                    wb_sel_o = WB_ALU;
                end
            end
            OP_REG: begin
                if (f7_ok) begin
                    alu_op_o = arith_op;
                    wb_sel_o = WB_ALU;
                end
            end
            OP_LOAD: begin
                wb_sel_o = WB_LOAD;
                case (funct3)
                    F3_LB:   mem_op_o = MEM_LB;
                    F3_LH:   mem_op_o = MEM_LH;
                    F3_LW:   mem_op_o = MEM_LW;
                    F3_LBU:  mem_op_o = MEM_LBU;
                    F3_LHU:  mem_op_o = MEM_LHU;
                    default: wb_sel_o = WB_NONE;
                endcase
            end
            OP_STORE: begin
                case (funct3)
                    F3_SB:   mem_op_o = MEM_SB;
                    F3_SH:   mem_op_o = MEM_SH;
                    F3_SW:   mem_op_o = MEM_SW;
                    default: mem_op_o = MEM_NONE;
                endcase
            end
            OP_BRANCH: begin
                case (funct3)
                    F3_BEQ:  br_cond_o = BR_EQ;
                    F3_BNE:  br_cond_o = BR_NE;
                    F3_BLT:  br_cond_o = BR_LT;
                    F3_BGE:  br_cond_o = BR_GE;
                    F3_BLTU: br_cond_o = BR_LTU;
                    F3_BGEU: br_cond_o = BR_GEU;
                    default: br_cond_o = BR_NONE;
                endcase
            end
            OP_JAL, OP_JALR: begin
                br_cond_o = BR_ALWAYS;
                wb_sel_o  = WB_ALU;  // link value
            end
            OP_LUI, OP_AUIPC: wb_sel_o = WB_ALU;
            OP_FENCE: br_cond_o = BR_ALWAYS;  // refetch from next pc
            default: wb_sel_o = WB_NONE;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/ex_mem_access.sv
/*
 * memory request, load lane extraction and store read-merge
 */
`timescale 1ns/1ps
`default_nettype none

module ex_mem_access (
    input  wire ex_pkg::mem_op_e mem_op_i,
    input  wire ex_pkg::word_t   addr_i,
    input  wire ex_pkg::word_t   store_data_i,
    input  wire ex_pkg::word_t   mem_rdata_i,
    input  wire                  int_assert_i,
    output logic                 mem_req_o,
    output logic                 mem_we_o,
    output ex_pkg::word_t        mem_raddr_o,
    output ex_pkg::word_t        mem_waddr_o,
    output ex_pkg::word_t        mem_wdata_o,
    output ex_pkg::word_t        load_data_o
);
    import ex_pkg::*;

    byte_off_t   off;
    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    word_t       sb_word;
    word_t       sh_word;
    logic        is_load;
    logic        is_store;

    assign off = addr_i[1:0];

    always_comb begin
        case (off)
            2'd0:    byte_lane = mem_rdata_i[7:0];
            2'd1:    byte_lane = mem_rdata_i[15:8];
            2'd2:    byte_lane = mem_rdata_i[23:16];
            default: byte_lane = mem_rdata_i[31:24];
        endcase
    end

    assign half_lane = (off == 2'd0) ? mem_rdata_i[15:0] : mem_rdata_i[31:16];

    // old word with the new byte or half dropped in
    always_comb begin
        case (off)
            2'd0:    sb_word = {mem_rdata_i[31:8], store_data_i[7:0]};
            2'd1:    sb_word = {mem_rdata_i[31:16], store_data_i[7:0], mem_rdata_i[7:0]};
            2'd2:    sb_word = {mem_rdata_i[31:24], store_data_i[7:0], mem_rdata_i[15:0]};
            default: sb_word = {store_data_i[7:0], mem_rdata_i[23:0]};
        endcase
    end

    assign sh_word = (off == 2'd0) ? {mem_rdata_i[31:16], store_data_i[15:0]}
                                   : {store_data_i[15:0], mem_rdata_i[15:0]};

    always_comb begin
        is_load     = 1'b0;
        is_store    = 1'b0;
        load_data_o = '0;
        mem_wdata_o = '0;
        case (mem_op_i)
            MEM_LB: begin
                is_load     = 1'b1;
                load_data_o = {{24{byte_lane[7]}}, byte_lane};
            end
            MEM_LH: begin
                is_load     = 1'b1;
                load_data_o = {{16{half_lane[15]}}, half_lane};
            end
            MEM_LW: begin
                is_load     = 1'b1;
                load_data_o = mem_rdata_i;
            end
            MEM_LBU: begin
                is_load     = 1'b1;
                load_data_o = {24'h0, byte_lane};
            end
            MEM_LHU: begin
                is_load     = 1'b1;
                load_data_o = {16'h0, half_lane};
            end
            MEM_SB: begin
                is_store    = 1'b1;
                mem_wdata_o = sb_word;
            end
            MEM_SH: begin
                is_store    = 1'b1;
                mem_wdata_o = sh_word;
            end
            MEM_SW: begin
                is_store    = 1'b1;
                mem_wdata_o = store_data_i;
            end
            default: is_load = 1'b0;
        endcase
    end

    // no bus access while an interrupt is taken
    assign mem_req_o   = (is_load || is_store) && !int_assert_i;
    assign mem_we_o    = is_store && !int_assert_i;
    assign mem_raddr_o = (is_load || is_store) ? addr_i : '0;  // stores read the old word
    assign mem_waddr_o = is_store ? addr_i : '0;

endmodule

`default_nettype wire

// File: verilog/ex_pkg.sv
/*
 * execute stage data types and operation classes
 */
`default_nettype none

`include "ex_defines.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0] word_t;
    typedef logic [1:0]          byte_off_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB,
        ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT,
        BR_GE, BR_LTU, BR_GEU, BR_ALWAYS
    } br_cond_e;

    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU,
        MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    // source of the register write-back value
    typedef enum logic [1:0] {
        WB_NONE, WB_ALU, WB_LOAD
    } wb_sel_e;

endpackage

`default_nettype wire

// File: verilog/ex_result.sv
/*
 * result stage: registers write-back and jump outputs,
 * with the interrupt taking over the jump
 */
`timescale 1ns/1ps
`default_nettype none

module ex_result (
    input  wire                       clk_i,
    input  wire                       rst_i,
    input  wire ex_pkg::wb_sel_e      wb_sel_i,
    input  wire                       reg_we_i,
    input  wire rv_isa_pkg::reg_addr_t reg_waddr_i,
    input  wire ex_pkg::word_t        alu_result_i,
    input  wire ex_pkg::word_t        load_data_i,
    input  wire                       take_jump_i,
    input  wire ex_pkg::word_t        jump_target_i,
    input  wire                       int_assert_i,
    input  wire ex_pkg::word_t        int_addr_i,
    output logic                      reg_we_o,
    output rv_isa_pkg::reg_addr_t     reg_waddr_o,
    output ex_pkg::word_t             reg_wdata_o,
    output logic                      jump_flag_o,
    output ex_pkg::word_t             jump_addr_o
);
    import ex_pkg::*;

    word_t wb_data;

    always_comb begin
        case (wb_sel_i)
            WB_ALU:  wb_data = alu_result_i;
            WB_LOAD: wb_data = load_data_i;
            default: wb_data = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            reg_we_o    <= 1'b0;
            reg_waddr_o <= '0;
            reg_wdata_o <= '0;
            jump_flag_o <= 1'b0;
            jump_addr_o <= '0;
        end else begin
            reg_waddr_o <= reg_waddr_i;
            reg_wdata_o <= wb_data;
            if (int_assert_i) begin
                reg_we_o    <= 1'b0;  // drop the write, redirect fetch
                jump_flag_o <= 1'b1;
                jump_addr_o <= int_addr_i;
            end else begin
                reg_we_o    <= reg_we_i;
                jump_flag_o <= take_jump_i;
                jump_addr_o <= jump_target_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/ex_top.sv
/*
 * integer execute stage: decode, ALU, branch, memory access
 * and the registered result stage
 */
`timescale 1ns/1ps
`default_nettype none

module ex_top (
    input  wire                        clk_i,
    input  wire                        rst_i,
    input  wire rv_isa_pkg::inst_t     inst_i,
    input  wire ex_pkg::word_t         inst_addr_i,
    input  wire                        reg_we_i,
    input  wire rv_isa_pkg::reg_addr_t reg_waddr_i,
    input  wire ex_pkg::word_t         op1_i,
    input  wire ex_pkg::word_t         op2_i,
    input  wire ex_pkg::word_t         op1_jump_i,
    input  wire ex_pkg::word_t         op2_jump_i,
    input  wire ex_pkg::word_t         reg1_rdata_i,
    input  wire ex_pkg::word_t         reg2_rdata_i,
    input  wire ex_pkg::word_t         mem_rdata_i,
    input  wire                        int_assert_i,
    input  wire ex_pkg::word_t         int_addr_i,
    output logic                       mem_req_o,
    output logic                       mem_we_o,
    output ex_pkg::word_t              mem_raddr_o,
    output ex_pkg::word_t              mem_waddr_o,
    output ex_pkg::word_t              mem_wdata_o,
    output logic                       reg_we_o,
    output rv_isa_pkg::reg_addr_t      reg_waddr_o,
    output ex_pkg::word_t              reg_wdata_o,
    output logic                       jump_flag_o,
    output ex_pkg::word_t              jump_addr_o
);
    import ex_pkg::*;

    alu_op_e  alu_op;
    br_cond_e br_cond;
    mem_op_e  mem_op;
    wb_sel_e  wb_sel;
    word_t    alu_result;   // also load/store address
    logic     lt_s;
    logic     lt_u;
    logic     eq;
    logic     take_jump;
    word_t    jump_target;
    word_t    load_data;

    ex_decode decode0 (
        .inst_i    (inst_i),
        .alu_op_o  (alu_op),
        .br_cond_o (br_cond),
        .mem_op_o  (mem_op),
        .wb_sel_o  (wb_sel)
    );

    ex_alu alu0 (
        .alu_op_i     (alu_op),
        .op1_i        (op1_i),
        .op2_i        (op2_i),
        .alu_result_o (alu_result),
        .lt_s_o       (lt_s),
        .lt_u_o       (lt_u),
        .eq_o         (eq)
    );

    ex_branch branch0 (
        .br_cond_i     (br_cond),
        .lt_s_i        (lt_s),
        .lt_u_i        (lt_u),
        .eq_i          (eq),
        .op1_jump_i    (op1_jump_i),
        .op2_jump_i    (op2_jump_i),
        .take_jump_o   (take_jump),
        .jump_target_o (jump_target)
    );

    ex_mem_access mem0 (
        .mem_op_i     (mem_op),
        .addr_i       (alu_result),
        .store_data_i (reg2_rdata_i),
        .mem_rdata_i  (mem_rdata_i),
        .int_assert_i (int_assert_i),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_raddr_o  (mem_raddr_o),
        .mem_waddr_o  (mem_waddr_o),
        .mem_wdata_o  (mem_wdata_o),
        .load_data_o  (load_data)
    );

    ex_result result0 (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .wb_sel_i      (wb_sel),
        .reg_we_i      (reg_we_i),
        .reg_waddr_i   (reg_waddr_i),
        .alu_result_i  (alu_result),
        .load_data_i   (load_data),
        .take_jump_i   (take_jump),
        .jump_target_i (jump_target),
        .int_assert_i  (int_assert_i),
        .int_addr_i    (int_addr_i),
        .reg_we_o      (reg_we_o),
        .reg_waddr_o   (reg_waddr_o),
        .reg_wdata_o   (reg_wdata_o),
        .jump_flag_o   (jump_flag_o),
        .jump_addr_o   (jump_addr_o)
    );

endmodule

`default_nettype wire

// File: verilog/rv_isa_pkg.sv
/*
 * RISC-V base integer instruction word, opcodes and function fields
 */
`default_nettype none

`include "ex_defines.svh"

package rv_isa_pkg;

    typedef logic [31:0]               inst_t;
    typedef logic [2:0]                funct3_t;
    typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_FENCE  = 7'b0001111
    } opcode_e;

    // register and immediate arithmetic
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SR      = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra

endpackage

`default_nettype wire
